// File: flist.f
+incdir+verilog
verilog/keccak_state_pkg.sv
verilog/sha3_stream_pkg.sv
verilog/sha3_padder.sv
verilog/keccak_round_const.sv
verilog/keccak_round.sv
verilog/keccak_permutation.sv
verilog/sha3_digest_out.sv
verilog/sha3_core.sv
verification/tb_clock_gen.sv
verification/sha3_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SHA3-256 testbench with Verilator.
# Exit status is nonzero if the build fails or the simulation stops on an error.

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f flist.f --top-module sha3_core_tb -o sha3_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sha3_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

// File: verification/sha3_core_tb.sv
// table-driven testbench for the sha3-256 core.
// fips 202 vectors, a behavioral sponge model, back-pressure and back-to-back messages.

`include "keccak_macros.svh"

module sha3_core_tb
    import keccak_state_pkg::*;
    import sha3_stream_pkg::*;
;

    localparam int rate_bytes  = `SHA3_RATE_LANES * 8;
    localparam int max_wait    = 500;   // cycles per handshake wait.
    localparam int stall_range = 16;    // back-pressure 0 to 15 cycles.

    // one table row.
    typedef struct packed {
        logic [15:0]  len;          // message bytes.
        logic         use_str;      // bytes from str, else all fill.
        logic [63:0]  str;          // short literal, last char in bits 7:0.
        logic [7:0]   fill;
        logic         chain;        // next entry follows with no gap.
        logic         known;        // published vector available.
        logic [255:0] published;    // fips 202 hex, first byte leftmost.
    } vector_t;

    logic      clk;
    logic      reset;
    logic      msg_valid;
    logic      msg_ready;
    msg_word_t msg;
    logic      digest_valid;
    logic      digest_ready;
    digest_t   digest;

    vector_t tbl [$];
    digest_t pending [$];      // digests owed by the DUT, in order.
    lane_t   ref_st [25];      // model state, lane x+5y.
    integer  seed;

    tb_clock_gen #(.period(8)) u_clk (.clk(clk));

    sha3_core DUT (
        .clk          (clk),
        .reset        (reset),
        .msg_valid    (msg_valid),
        .msg_ready    (msg_ready),
        .msg          (msg),
        .digest_valid (digest_valid),
        .digest_ready (digest_ready),
        .digest       (digest)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // error handling and compares
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_digest(input string name, input digest_t exp, input digest_t act);
        if (act !== exp) begin
            stop_run($sformatf("Mismatch at time %0t: %s expected %h, actual %h",
                               $time, name, exp, act));
        end
    endtask

    task automatic verify_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("Mismatch at time %0t: %s expected %b, actual %b",
                               $time, name, exp, act));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // vector table helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic add_vector(input logic [15:0] len, input logic use_str,
                              input logic [63:0] str, input logic [7:0] fill,
                              input logic chain, input logic known,
                              input logic [255:0] published);
        tbl.push_back('{len, use_str, str, fill, chain, known, published});
    endtask

    function automatic logic [7:0] msg_byte(input int entry, input int i);
        vector_t v;
        v = tbl[entry];
        if (v.use_str) return v.str[8*(int'(v.len)-1-i) +: 8];  // first char is highest.
        return v.fill;
    endfunction

    // hex text order to digest byte order.
    function automatic digest_t published_to_digest(input logic [255:0] h);
        digest_t d;
        for (int k = 0; k < 32; k++) d[8*k +: 8] = h[255-8*k -: 8];
        return d;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // behavioral sponge model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic lane_t rotate_left(input lane_t v, input int n);
        return (n == 0) ? v : ((v << n) | (v >> (64 - n)));
    endfunction

    task automatic keccak_f_model();
        lane_t      c [5];
        lane_t      cur;
        lane_t      tmp;
        logic [7:0] lfsr;
        int         x;
        int         y;
        int         yn;
        lfsr = 8'h01;
        for (int rnd = 0; rnd < `KECCAK_ROUNDS; rnd++) begin
            for (int i = 0; i < 5; i++) begin
                c[i] = ref_st[i] ^ ref_st[i+5] ^ ref_st[i+10] ^ ref_st[i+15] ^ ref_st[i+20];
            end
            for (int i = 0; i < 25; i++) begin
                ref_st[i] ^= c[(i+4)%5] ^ rotate_left(c[(i+1)%5], 1);   // theta.
            end
            // rho and pi as one walk over 24 lanes.
            x   = 1;
            y   = 0;
            cur = ref_st[1];
            for (int t = 0; t < 24; t++) begin
                yn             = (2*x + 3*y) % 5;
                x              = y;
                y              = yn;
                tmp            = ref_st[x+5*y];
                ref_st[x+5*y]  = rotate_left(cur, ((t+1)*(t+2)/2) % 64);
                cur            = tmp;
            end
            for (int j = 0; j < 25; j += 5) begin
                for (int i = 0; i < 5; i++) c[i] = ref_st[j+i];
                for (int i = 0; i < 5; i++) begin
                    ref_st[j+i] = c[i] ^ (~c[(i+1)%5] & c[(i+2)%5]);   // chi.
                end
            end
            // iota bits straight from the lfsr.
            for (int j = 0; j < 7; j++) begin
                if (lfsr[0]) ref_st[0][(1<<j)-1] ^= 1'b1;
                lfsr = lfsr[7] ? ((lfsr << 1) ^ 8'h71) : (lfsr << 1);
            end
        end
    endtask

    task automatic sha3_model(input int entry, output digest_t d);
        int         n;
        int         nblk;
        int         p;
        logic [7:0] pb;
        n    = tbl[entry].len;
        nblk = n / rate_bytes + 1;     // padding needs at least one byte.
        for (int i = 0; i < 25; i++) ref_st[i] = '0;
        for (int b = 0; b < nblk; b++) begin
            for (int k = 0; k < rate_bytes; k++) begin
                p  = b*rate_bytes + k;
                pb = (p < n) ? msg_byte(entry, p) : 8'h00;
                if (p == n) pb = 8'h06;                            // domain bits.
                if (b == nblk-1 && k == rate_bytes-1) pb |= 8'h80; // final pad bit.
                ref_st[k/8][8*(k%8) +: 8] ^= pb;
            end
            keccak_f_model();
        end
        for (int k = 0; k < 32; k++) d[8*k +: 8] = ref_st[k/8][8*(k%8) +: 8];
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stream drivers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic feed_message(input int entry);
        int        n;
        int        nwords;
        int        cnt;
        msg_word_t w;
        n      = tbl[entry].len;
        nwords = (n == 0) ? 1 : (n + 7) / 8;
        for (int wi = 0; wi < nwords; wi++) begin
            w.last   = (wi == nwords - 1);
            w.nbytes = w.last ? byte_cnt_t'(n - 8*wi) : byte_cnt_t'(8);
            for (int b = 0; b < 8; b++) begin
                w.data[8*b +: 8] = (8*wi + b < n) ? msg_byte(entry, 8*wi + b) : 8'hee;
            end
            msg       = w;
            msg_valid = 1'b1;
            cnt       = 0;
            while (!msg_ready) begin
                @(posedge clk);
                #1;
                cnt++;
                if (cnt >= max_wait) stop_run("timeout: msg_ready stayed low for 500 cycles");
            end
            @(posedge clk);    // word transfers here.
            #1;
        end
        msg_valid = 1'b0;
    endtask

    task automatic collect_digest(input digest_t expected);
        int      cnt;
        int      stall;
        digest_t held;
        cnt = 0;
        while (!digest_valid) begin
            @(posedge clk);
            #1;
            cnt++;
            if (cnt >= max_wait) stop_run("timeout: no digest_valid within 500 cycles");
        end
        held  = digest;
        stall = $unsigned($random(seed)) % stall_range;
        for (int s = 0; s < stall; s++) begin
            @(posedge clk);
            #1;
            verify_flag("digest_valid", 1'b1, digest_valid);
            compare_digest("digest", held, digest);     // stable under back-pressure.
        end
        compare_digest("digest", expected, digest);
        digest_ready = 1'b1;
        @(posedge clk);
        #1;
        digest_ready = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        digest_t expected;
        seed         = 43;
        reset        = 1'b1;
        msg_valid    = 1'b0;
        msg          = '0;
        digest_ready = 1'b0;

        add_vector(16'd0, 1'b0, 64'h0, 8'h00, 1'b0, 1'b1,
                   256'ha7ffc6f8bf1ed76651c14756a061d662_f580ff4de43b49fa82d80a4b80f8434a);
        add_vector(16'd3, 1'b1, "abc", 8'h00, 1'b0, 1'b1,
                   256'h3a985da74fe225b2045c172d6bd390bd_855f086e3e9d525b46bfe24511431532);
        add_vector(16'd200, 1'b0, 64'h0, 8'ha3, 1'b0, 1'b1,
                   256'h79f38adec5c20307a98ef76e8324afbf_d46cfd81b22e3973c65fa1bd9de31787);
        // block filled exactly, extra padding block.
        add_vector(16'd136, 1'b0, 64'h0, 8'ha3, 1'b0, 1'b0, 256'h0);
        // 0x86 merged pad byte.
        add_vector(16'd135, 1'b0, 64'h0, 8'ha3, 1'b0, 1'b0, 256'h0);
        // back to back pair.
        add_vector(16'd200, 1'b0, 64'h0, 8'ha3, 1'b1, 1'b1,
                   256'h79f38adec5c20307a98ef76e8324afbf_d46cfd81b22e3973c65fa1bd9de31787);
        add_vector(16'd3, 1'b1, "abc", 8'h00, 1'b0, 1'b1,
                   256'h3a985da74fe225b2045c172d6bd390bd_855f086e3e9d525b46bfe24511431532);

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        verify_flag("msg_ready", 1'b1, msg_ready);
        verify_flag("digest_valid", 1'b0, digest_valid);

        for (int i = 0; i < tbl.size(); i++) begin
            sha3_model(i, expected);
            if (tbl[i].known) begin
                compare_digest("reference model", published_to_digest(tbl[i].published),
                               expected);
            end
            pending.push_back(expected);
            feed_message(i);
            if (!tbl[i].chain) begin
                while (pending.size() > 0) collect_digest(pending.pop_front());
            end
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: verification/tb_clock_gen.sv
// testbench clock source.
// free-running clock, low at time zero.

module tb_clock_gen #(
    parameter int period = 8
) (
    output logic clk
);

    initial clk = 1'b0;
    always #(period / 2) clk = ~clk;   // 50% duty.

endmodule

// File: verilog/sha3_core.sv
// sha3-256 core top: padder, permutation and digest stages.

module sha3_core
    import sha3_stream_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      msg_valid,
    output logic      msg_ready,
    input  msg_word_t msg,
    output logic      digest_valid,
    input  logic      digest_ready,
    output digest_t   digest
);

    // padder to permutation.
    logic        blk_valid;
    logic        blk_ready;
    rate_block_t blk;
    // permutation to digest stage.
    logic        st_valid;
    logic        st_ready;
    digest_t     st_digest;

    sha3_padder u_padder (
        .clk       (clk),
        .reset     (reset),
        .msg_valid (msg_valid),
        .msg_ready (msg_ready),
        .msg       (msg),
        .blk_valid (blk_valid),
        .blk_ready (blk_ready),
        .blk       (blk)
    );

    keccak_permutation u_permutation (
        .clk       (clk),
        .reset     (reset),
        .blk_valid (blk_valid),
        .blk_ready (blk_ready),
        .blk       (blk),
        .st_valid  (st_valid),
        .st_ready  (st_ready),
        .st_digest (st_digest)
    );

    sha3_digest_out u_digest_out (
        .clk          (clk),
        .reset        (reset),
        .st_valid     (st_valid),
        .st_ready     (st_ready),
        .st_digest    (st_digest),
        .digest_valid (digest_valid),
        .digest_ready (digest_ready),
        .digest       (digest)
    );

endmodule

// File: verilog/sha3_digest_out.sv
// third pipeline stage: one-entry holding register for the digest.

module sha3_digest_out
    import sha3_stream_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    st_valid,
    output logic    st_ready,
    input  digest_t st_digest,
    output logic    digest_valid,
    input  logic    digest_ready,
    output digest_t digest
);

    logic load;

    // take a new digest when empty or when the held one leaves.
    assign st_ready = !digest_valid || digest_ready;
    assign load     = st_valid && st_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            digest_valid <= 1'b0;
        end else if (load) begin
            digest_valid <= 1'b1;
        end else if (digest_ready) begin
            digest_valid <= 1'b0;   // consumer took it.
        end
    end

    // digest payload, held stable while valid.
    always_ff @(posedge clk) begin
        if (load) digest <= st_digest;
    end

endmodule

// File: verilog/keccak_permutation.sv
// second pipeline stage: absorbs rate blocks into the chaining state.
// runs the 24 rounds one per clock and offers the final digest lanes.

`include "keccak_macros.svh"

module keccak_permutation
    import keccak_state_pkg::*;
    import sha3_stream_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        blk_valid,
    output logic        blk_ready,
    input  rate_block_t blk,
    output logic        st_valid,
    input  logic        st_ready,
    output digest_t     st_digest
);

    perm_state_e fsm;
    round_idx_t  round_cnt;     // round applied at the next edge in run.
    round_idx_t  round_sel;
    logic        last_q;        // block in flight ends the message.
    logic        accept;
    logic        final_round;
    state_t      state;
    state_t      round_in;
    state_t      round_out;
    lane_t       rc;

    assign blk_ready   = (fsm == IDLE);
    assign accept      = blk_valid && blk_ready;
    assign final_round = (fsm == RUN) && (round_cnt == round_idx_t'(`KECCAK_ROUNDS - 1));

    // round 0 runs on the accept edge over state xor block.
    assign round_sel = accept ? '0 : round_cnt;
    assign round_in  = accept ? (state ^ state_t'(blk.data)) : state;

    keccak_round_const u_round_const (
        .round_idx (round_sel),
        .rc        (rc)
    );

    keccak_round u_round (
        .state_in  (round_in),
        .rc        (rc),
        .state_out (round_out)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // round sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            fsm       <= IDLE;
            round_cnt <= '0;
            last_q    <= 1'b0;
            state     <= '0;
        end else begin
            case (fsm)
                IDLE: if (accept) begin
                    fsm       <= RUN;
                    round_cnt <= round_idx_t'(1);
                    last_q    <= blk.last;
                    state     <= round_out;
                end
                RUN: begin
                    state     <= round_out;
                    round_cnt <= round_cnt + round_idx_t'(1);
                    if (final_round) fsm <= last_q ? HOLD : IDLE;
                end
                HOLD: if (st_ready) begin
                    state <= '0;    // next message starts from zero.
                    fsm   <= IDLE;
                end
                default: fsm <= IDLE;
            endcase
        end
    end

    assign st_valid  = (fsm == HOLD);
    assign st_digest = state[`SHA3_DIGEST_W-1:0];  // lanes 0 to 3.

endmodule

// File: verilog/keccak_round.sv
// one keccak-f[1600] round: theta, rho, pi, chi, iota.
// purely combinational, a[x][y] is lane x+5y of the state.

`include "keccak_macros.svh"

module keccak_round
    import keccak_state_pkg::*;
(
    input  state_t state_in,
    input  lane_t  rc,
    output state_t state_out
);

    localparam int lane_w = `KECCAK_LANE_W;

    // rho rotation per lane, indexed [x][y].
    localparam int rho_ofs [5][5] = '{
        '{ 0, 36,  3, 41, 18},
        '{ 1, 44, 10, 45,  2},
        '{62,  6, 43, 15, 61},
        '{28, 55, 25, 21, 56},
        '{27, 20, 39,  8, 14}
    };

    lane_t a [5][5];    // input lanes.
    lane_t b [5][5];    // after theta, rho and pi.
    lane_t c [5];       // column parity.
    lane_t d [5];       // theta term per column.

    function automatic lane_t rotl(lane_t v, int n);
        return (v << n) | (v >> (lane_w - n));  // n = 0 leaves v.
    endfunction

    always_comb begin
        for (int x = 0; x < 5; x++) begin
            for (int y = 0; y < 5; y++) begin
                a[x][y] = state_in[lane_w*(x+5*y) +: lane_w];
            end
        end
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // theta
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        for (int x = 0; x < 5; x++) begin
            c[x] = a[x][0] ^ a[x][1] ^ a[x][2] ^ a[x][3] ^ a[x][4];
        end
        for (int x = 0; x < 5; x++) begin
            d[x] = c[(x+4)%5] ^ rotl(c[(x+1)%5], 1);   // left and right neighbours.
        end
        // rho and pi together, lane (x,y) moves to (y, 2x+3y).
        for (int x = 0; x < 5; x++) begin
            for (int y = 0; y < 5; y++) begin
                b[y][(2*x+3*y)%5] = rotl(a[x][y] ^ d[x], rho_ofs[x][y]);
            end
        end
        // chi along each row.
        for (int x = 0; x < 5; x++) begin
            for (int y = 0; y < 5; y++) begin
                state_out[lane_w*(x+5*y) +: lane_w] =
                    b[x][y] ^ (~b[(x+1)%5][y] & b[(x+2)%5][y]);
            end
        end
        state_out[lane_w-1:0] ^= rc;    // iota on lane 0 only.
    end

endmodule

// File: verilog/keccak_round_const.sv
// iota round constant table for keccak-f[1600].

module keccak_round_const
    import keccak_state_pkg::*;
(
    input  round_idx_t round_idx,
    output lane_t      rc
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // iota constants from the fips 202 lfsr
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (round_idx)
            5'd0:    rc = 64'h0000_0000_0000_0001;
            5'd1:    rc = 64'h0000_0000_0000_8082;
            5'd2:    rc = 64'h8000_0000_0000_808a;
            5'd3:    rc = 64'h8000_0000_8000_8000;
            5'd4:    rc = 64'h0000_0000_0000_808b;
            5'd5:    rc = 64'h0000_0000_8000_0001;
            5'd6:    rc = 64'h8000_0000_8000_8081;
            5'd7:    rc = 64'h8000_0000_0000_8009;
            5'd8:    rc = 64'h0000_0000_0000_008a;
            5'd9:    rc = 64'h0000_0000_0000_0088;
            5'd10:   rc = 64'h0000_0000_8000_8009;
            5'd11:   rc = 64'h0000_0000_8000_000a;
            5'd12:   rc = 64'h0000_0000_8000_808b;
            5'd13:   rc = 64'h8000_0000_0000_008b;
            5'd14:   rc = 64'h8000_0000_0000_8089;
            5'd15:   rc = 64'h8000_0000_0000_8003;
            5'd16:   rc = 64'h8000_0000_0000_8002;
            5'd17:   rc = 64'h8000_0000_0000_0080;
            5'd18:   rc = 64'h0000_0000_0000_800a;
            5'd19:   rc = 64'h8000_0000_8000_000a;
            5'd20:   rc = 64'h8000_0000_8000_8081;
            5'd21:   rc = 64'h8000_0000_0000_8080;
            5'd22:   rc = 64'h0000_0000_8000_0001;
            5'd23:   rc = 64'h8000_0000_8000_8008;
            default: rc = '0;   // counter parks at 24 between blocks.
        endcase
    end

endmodule

// File: verilog/sha3_padder.sv
// first pipeline stage: message lanes into 1088-bit rate blocks.
// applies sha-3 domain padding and the extra padding-only block.

`include "keccak_macros.svh"

module sha3_padder
    import sha3_stream_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        msg_valid,
    output logic        msg_ready,
    input  msg_word_t   msg,
    output logic        blk_valid,
    input  logic        blk_ready,
    output rate_block_t blk
);

    localparam int lane_bytes = `KECCAK_LANE_W / 8;
    localparam int rate_bytes = `SHA3_RATE_LANES * lane_bytes;
    // padding with no message bytes: 0x06 first, 0x80 last.
    localparam logic [rate_bytes*8-1:0] pad_only = {8'h80, {(rate_bytes-2)*8{1'b0}}, 8'h06};

    logic [4:0]  lane_cnt;      // next lane slot in block.
    logic        pad_pending;   // padding-only block still owed.
    logic        accept;
    logic        last_lane;
    logic [7:0]  end_pos;       // first byte after the message.
    logic        no_room;
    rate_block_t blk_next;

    assign msg_ready = !blk_valid;      // stall while a block waits.
    assign accept    = msg_valid && msg_ready;
    assign last_lane = (lane_cnt == 5'(`SHA3_RATE_LANES - 1));
    assign end_pos   = {lane_cnt, 3'b000} + msg.nbytes;
    assign no_room   = (end_pos == 8'(rate_bytes));   // full word in lane 16.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lane placement and padding
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        logic [`KECCAK_LANE_W-1:0] word;
        word = msg.data;
        if (msg.last) begin
            for (int b = 0; b < lane_bytes; b++) begin
                if (b >= msg.nbytes) word[8*b +: 8] = 8'h00;   // drop unused bytes.
            end
        end
        blk_next.data = (lane_cnt == '0) ? '0 : blk.data;  // fresh block starts clean.
        blk_next.data[lane_cnt*`KECCAK_LANE_W +: `KECCAK_LANE_W] = word;
        blk_next.last = msg.last && !no_room;
        // 0x06 and 0x80 merge to 0x86 when end_pos is 135.
        if (msg.last && !no_room) begin
            blk_next.data[end_pos*8 +: 8] |= 8'h06;
            blk_next.data[rate_bytes*8-1 -: 8] |= 8'h80;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lane_cnt    <= '0;
            pad_pending <= 1'b0;
            blk_valid   <= 1'b0;
        end else if (accept) begin
            if (msg.last || last_lane) begin
                lane_cnt    <= '0;
                blk_valid   <= 1'b1;
                pad_pending <= msg.last && no_room;
            end else begin
                lane_cnt <= lane_cnt + 5'd1;
            end
        end else if (blk_valid && blk_ready) begin
            blk_valid   <= pad_pending;     // stay up for the padding block.
            pad_pending <= 1'b0;
        end
    end

    // block payload.
    always_ff @(posedge clk) begin
        if (accept) begin
            blk <= blk_next;
        end else if (blk_valid && blk_ready && pad_pending) begin
            blk.data <= pad_only;
            blk.last <= 1'b1;
        end
    end

endmodule

// File: verilog/sha3_stream_pkg.sv
// stream-side types.
// message word, byte count, rate block and digest.

`include "keccak_macros.svh"

package sha3_stream_pkg;

    // valid bytes in the last word, 0 to 8.
    typedef logic [3:0] byte_cnt_t;

    // one message word; first message byte in data[7:0].
    // nbytes only counts on the last word, earlier words are full.
    typedef struct packed {
        logic [`KECCAK_LANE_W-1:0] data;
        logic                      last;
        byte_cnt_t                 nbytes;
    } msg_word_t;

    // one padded rate block, lane k at data[64k +: 64].
    typedef struct packed {
        logic [`SHA3_RATE_LANES*`KECCAK_LANE_W-1:0] data;
        logic                                       last;   // final block of message.
    } rate_block_t;

    // digest byte k at bits 8k+7:8k.
    typedef logic [`SHA3_DIGEST_W-1:0] digest_t;

endpackage

// File: verilog/keccak_state_pkg.sv
// permutation-side types.
// lane, full state, round index and the permutation fsm encoding.

`include "keccak_macros.svh"

package keccak_state_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one lane, bytes little-endian.
    typedef logic [`KECCAK_LANE_W-1:0] lane_t;

    // lane x+5y at bits 64*(x+5y) upward.
    typedef logic [`KECCAK_LANES*`KECCAK_LANE_W-1:0] state_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // round sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // round 0 to 23; the iota constant is a lane_t.
    typedef logic [$clog2(`KECCAK_ROUNDS)-1:0] round_idx_t;

    // idle waits for a block, run steps rounds,
    // hold presents the final state downstream.
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        HOLD
    } perm_state_e;

endpackage

// File: verilog/keccak_macros.svh
// shared constants for the sha3-256 core.
// lane geometry, round count and the sha3-256 rate/digest sizes.

`ifndef KECCAK_MACROS_SVH
`define KECCAK_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// keccak-f[1600] geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// bits in one lane.
`define KECCAK_LANE_W 64
// 5 x 5 lanes in the state.
`define KECCAK_LANES 25
// rounds of one permutation.
`define KECCAK_ROUNDS 24

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sha3-256 sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// rate of 1088 bits, 136 bytes.
`define SHA3_RATE_LANES 17
// capacity is the remaining 8 lanes.
// digest is the low four lanes of the state.
`define SHA3_DIGEST_W 256

`endif
